// File: board_top.f
design/board_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/board_parser.sv
design/board_tally.sv
design/board_top.sv
tb/board_top_tb.sv

// File: design/board_parser.sv
`timescale 1ns/1ps
`default_nettype none

module board_parser
    import board_pkg::*;
(
    input  wire            clk_100mhz,
    input  wire            rst_n,
    input  wire uart_byte_t rx_byte,
    input  wire            rx_valid,
    output board_t         board,       // Stable until the next header
    output logic           board_done   // One cycle after the end byte strobe
);

    parser_state_t state;

    logic     is_hdr;
    logic     is_end;
    logic     is_asg;
    row_idx_t asg_row;
    col_idx_t asg_col;
    logic     asg_val;

    // Byte classification
    assign is_hdr = (rx_byte & HDR_FLAG) == HDR_FLAG;
    assign is_end = rx_byte == END_BYTE;
    assign is_asg = !rx_byte[7];  // Any byte with bit 7 clear

    // Assignment fields 0rrrcccv
    assign asg_row = rx_byte[6:4];
    assign asg_col = rx_byte[3:1];
    assign asg_val = rx_byte[0];

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state      <= WAIT_HDR;
            board_done <= 1'b0;
        end else begin
            board_done <= 1'b0;
            if (rx_valid) begin
                if (is_hdr) begin
                    state <= LOAD;  // A header restarts from either state
                end else if (state == LOAD && is_end) begin
                    board_done <= 1'b1;
                    state      <= WAIT_HDR;
                end
            end
        end
    end

    // Board register
    // Writes outside the header's rows and cols are kept, the tally masks them
    always_ff @(posedge clk_100mhz) begin
        if (rx_valid) begin
            if (is_hdr) begin
                board.rows  <= rx_byte[5:3];
                board.cols  <= rx_byte[2:0];
                board.cells <= '0;  // New board starts all false
            end else if (state == LOAD && is_asg) begin
                board.cells[asg_row][asg_col] <= asg_val;
            end
        end
    end

    // Strobes are a full frame apart, so done can never stretch
    a_done_single: assert property (
        @(posedge clk_100mhz) disable iff (!rst_n) board_done |=> !board_done
    );

endmodule

`default_nettype wire

// File: design/board_pkg.sv
`default_nettype none

package board_pkg;

    // Board limit, fixed by the 3-bit row and column fields of the byte encoding
    parameter int MAX_ROWS = 8;
    parameter int MAX_COLS = 8;

    typedef logic [$clog2(MAX_ROWS)-1:0] row_idx_t;  // Row index
    typedef logic [$clog2(MAX_COLS)-1:0] col_idx_t;  // Column index

    // One board row, bit c is column c, 1 = true
    typedef logic [MAX_COLS-1:0] row_bits_t;

    typedef logic [7:0] tally_t;      // True cells in one row
    typedef logic [7:0] uart_byte_t;  // Byte on the serial line

    // Board register as decoded from the host stream
    typedef struct packed {
        row_idx_t                   rows;   // Row count minus 1
        col_idx_t                   cols;   // Column count minus 1
        row_bits_t [MAX_ROWS-1:0]   cells;  // Cell values, row r at index r
    } board_t;

    // Command bytes
    // Header  11rrrccc, rows-1 and cols-1
    // Assign  0rrrcccv, row, column, value
    // End     10000000
    localparam uart_byte_t END_BYTE = 8'h80;
    localparam uart_byte_t HDR_FLAG = 8'hC0;  // Both upper bits set marks a header

    // Decoder FSM
    typedef enum logic {
        WAIT_HDR,  // Ignoring everything but a header
        LOAD       // Taking assignments until the end byte
    } parser_state_t;

    // Tally engine FSM
    typedef enum logic [1:0] {
        IDLE,
        SEND,
        WAIT_TX
    } tally_state_t;

endpackage

`default_nettype wire

// File: design/board_tally.sv
`timescale 1ns/1ps
`default_nettype none

module board_tally
    import board_pkg::*;
(
    input  wire        clk_100mhz,
    input  wire        rst_n,
    input  wire board_t board,
    input  wire        board_done,
    input  wire        tx_busy,
    output logic       tx_start,
    output tally_t     tx_byte,
    output logic [7:0] led        // Boards tallied, wraps at 256
);

    tally_state_t state;
    board_t       snap;       // Board copy taken on board_done
    row_idx_t     row;        // Row being sent
    row_bits_t    col_mask;   // Ones for columns inside the board
    row_bits_t    row_cells;
    tally_t       count;

    assign col_mask  = row_bits_t'(8'hFF) >> (3'd7 - snap.cols);
    assign row_cells = snap.cells[row] & col_mask;

    // Popcount of the masked row
    always_comb begin
        count = '0;
        for (int c = 0; c < MAX_COLS; c++) begin
            count = count + tally_t'(row_cells[c]);
        end
    end

    // Start goes out in the same cycle the transmitter is seen free
    assign tx_start = (state == SEND) && !tx_busy;
    assign tx_byte  = count;

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            row   <= '0;
            led   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (board_done) begin
                        row   <= '0;
                        state <= SEND;
                    end
                end
                SEND: if (!tx_busy) state <= WAIT_TX;
                WAIT_TX: begin
                    if (!tx_busy) begin  // Frame finished
                        if (row == snap.rows) begin
                            led   <= led + 1'b1;
                            state <= IDLE;
                        end else begin
                            row   <= row + 1'b1;
                            state <= SEND;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Done while busy is dropped here, that board is lost
    always_ff @(posedge clk_100mhz) begin
        if (state == IDLE && board_done) snap <= board;
    end

    // Every start is followed by a busy transmitter and the engine waiting on it
    a_start_handshake: assert property (
        @(posedge clk_100mhz) disable iff (!rst_n)
        tx_start |-> (state == SEND) ##1 (tx_busy && state == WAIT_TX)
    );

endmodule

`default_nettype wire

// File: design/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top
    import board_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868  // 115200 baud at 100 MHz
) (
    input  wire        clk_100mhz,
    input  wire        rst_n,
    input  wire        rx,
    output logic       tx,
    output logic [7:0] led
);

    uart_byte_t rx_byte;
    logic       rx_valid;
    board_t     board;
    logic       board_done;
    tally_t     tx_byte;
    logic       tx_start;
    logic       tx_busy;

    // Serial in
    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .rx         (rx),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid)
    );

    // Decode stage
    board_parser i_board_parser (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .rx_byte    (rx_byte),
        .rx_valid   (rx_valid),
        .board      (board),
        .board_done (board_done)
    );

    // Execute stage
    board_tally i_board_tally (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .board      (board),
        .board_done (board_done),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .led        (led)
    );

    // Result stage, serial out
    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_tx (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .tx_start   (tx_start),
        .tx_byte    (tx_byte),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import board_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868  // Clock cycles per bit
) (
    input  wire        clk_100mhz,
    input  wire        rst_n,
    input  wire        rx,
    output uart_byte_t rx_byte,
    output logic       rx_valid  // One cycle per good frame
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_CNT = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t        state;
    logic             rx_meta, rx_sync, rx_prev;  // Sync chain plus edge history
    logic [CNT_W-1:0] clk_cnt;                    // Bit-time counter
    logic [2:0]       bit_idx;                    // Data bit in flight
    uart_byte_t       shift;
    logic             sample;

    // Data bits sampled one bit-time after the start bit middle
    assign sample  = (state == RX_DATA) && (clk_cnt == LAST_CNT);
    assign rx_byte = shift;  // Holds after the stop bit

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;  // Line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) state <= RX_START;  // Falling edge
                end
                RX_START: begin
                    if (clk_cnt == HALF_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;  // Glitch check
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (clk_cnt == LAST_CNT) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (clk_cnt == LAST_CNT) begin
                        rx_valid <= rx_sync;  // Framing error drops the byte
                        state    <= RX_IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB first
    always_ff @(posedge clk_100mhz) begin
        if (sample) shift <= {rx_sync, shift[7:1]};
    end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import board_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
) (
    input  wire        clk_100mhz,
    input  wire        rst_n,
    input  wire        tx_start,  // Strobe, only while idle
    input  wire tally_t tx_byte,
    output logic       tx,
    output logic       tx_busy   // High from the cycle after tx_start to the end of stop
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bits_left;  // Data plus stop bits still to go
    logic [8:0]       shift;      // Stop bit above the data byte
    logic             load;
    logic             bit_end;

    assign load    = tx_start && !tx_busy;
    assign bit_end = tx_busy && (clk_cnt == LAST_CNT);

    always_ff @(posedge clk_100mhz or negedge rst_n) begin
        if (!rst_n) begin
            tx        <= 1'b1;
            tx_busy   <= 1'b0;
            clk_cnt   <= '0;
            bits_left <= '0;
        end else if (load) begin
            tx        <= 1'b0;  // Start bit
            tx_busy   <= 1'b1;
            clk_cnt   <= '0;
            bits_left <= 4'd9;
        end else if (tx_busy) begin
            if (bit_end) begin
                clk_cnt <= '0;
                if (bits_left == 4'd0) begin
                    tx_busy <= 1'b0;  // Stop bit done, line already high
                end else begin
                    tx        <= shift[0];
                    bits_left <= bits_left - 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        if (load) begin
            shift <= {1'b1, tx_byte};
        end else if (bit_end) begin
            shift <= {1'b1, shift[8:1]};  // Next bit to bit 0
        end
    end

    // The tally engine must wait for a free transmitter
    a_no_start_while_busy: assert property (
        @(posedge clk_100mhz) disable iff (!rst_n) tx_start |-> !tx_busy
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the board tally testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    --top-module board_top_tb \
    -f board_top.f \
    --Mdir "$OBJ" -o board_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/board_top_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/board_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module board_top_tb
    import board_pkg::*;
();

    localparam int CLKS_PER_BIT = 16;
    localparam int N_SENT = 118;  // Host bytes over all five tests
    localparam int N_EXP  = 25;   // Tally bytes expected back
    localparam int TIMEOUT_CYCLES = (N_SENT + N_EXP) * 12 * CLKS_PER_BIT * 2;

    logic       clk_100mhz;
    logic       rst_n;
    logic       rx;
    logic       tx;
    logic [7:0] led;

    board_t     model;           // Board as the host built it
    uart_byte_t rx_q[$];         // Bytes decoded from tx
    tally_t     exp_q[$];        // Expected tallies in order
    bit         last_q[$];       // Marks the final row of a board
    int         errors = 0;
    int         boards_sent = 0;
    int         boards_checked = 0;

    board_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_board_top (
        .clk_100mhz (clk_100mhz),
        .rst_n      (rst_n),
        .rx         (rx),
        .tx         (tx),
        .led        (led)
    );

    initial begin
        clk_100mhz = 1'b0;
        forever #5 clk_100mhz = ~clk_100mhz;
    end

    // Expected count per row, only cells inside the header's rows and cols
    function automatic logic [MAX_ROWS-1:0][7:0] ref_tally(input board_t b);
        logic [MAX_ROWS-1:0][7:0] counts;
        counts = '0;
        for (int r = 0; r <= int'(b.rows); r++) begin
            for (int c = 0; c <= int'(b.cols); c++) begin
                if (b.cells[r][c]) counts[r] = counts[r] + 8'd1;
            end
        end
        return counts;
    endfunction

    task automatic check_eq(input logic [7:0] got, input logic [7:0] want, input string what);
        if (got !== want) begin
            $display("Mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, want);
            errors++;
        end
    endtask

    // Start bit, data LSB first, then the given stop bit
    task automatic send_frame(input uart_byte_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk_100mhz);
            #1 rx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk_100mhz);
        end
        if (!stop_bit) begin  // Back to idle before the next start
            @(posedge clk_100mhz);
            #1 rx = 1'b1;
            repeat (2 * CLKS_PER_BIT - 1) @(posedge clk_100mhz);
        end
    endtask

    task automatic send_byte(input uart_byte_t data);
        send_frame(data, 1'b1);
    endtask

    task automatic send_header(input int n_rows, input int n_cols);
        model.rows  = 3'(n_rows - 1);
        model.cols  = 3'(n_cols - 1);
        model.cells = '0;                // Header wipes the board
        send_byte({2'b11, 3'(n_rows - 1), 3'(n_cols - 1)});
    endtask

    task automatic send_assign(input int r, input int c, input logic v);
        model.cells[r][c] = v;
        send_byte({1'b0, 3'(r), 3'(c), v});
    endtask

    // Queue the expected tallies, send the end byte and wait for the comparer
    task automatic finish_board();
        logic [MAX_ROWS-1:0][7:0] counts;
        counts = ref_tally(model);
        for (int r = 0; r <= int'(model.rows); r++) begin
            exp_q.push_back(counts[r]);
            last_q.push_back(r == int'(model.rows));
        end
        boards_sent++;
        send_byte(8'h80);
        while (boards_checked != boards_sent) @(negedge clk_100mhz);
    endtask

    // Receive monitor, samples tx mid-bit on the falling clock edge
    initial begin : monitor_tx
        uart_byte_t data;
        forever begin
            @(negedge tx);
            repeat (CLKS_PER_BIT / 2) @(negedge clk_100mhz);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(negedge clk_100mhz);
                data[i] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk_100mhz);
            if (tx !== 1'b1) begin
                $display("Stop bit on tx was low at %0t ns", $time);
                errors++;
            end
            rx_q.push_back(data);
        end
    end

    // Comparer
    initial begin : compare_tx
        uart_byte_t got;
        tally_t     want;
        bit         last;
        logic [7:0] want_led;
        forever begin
            while (rx_q.size() == 0) @(negedge clk_100mhz);
            got = rx_q.pop_front();
            if (exp_q.size() == 0) begin
                $display("Byte %h appeared on tx with no board pending at %0t ns", got, $time);
                errors++;
            end else begin
                want = exp_q.pop_front();
                last = last_q.pop_front();
                check_eq(got, want, "row tally");
                if (last) begin
                    want_led = 8'(boards_checked + 1);
                    // Counter steps once the stop bit is out
                    for (int i = 0; i < 2 * CLKS_PER_BIT && led !== want_led; i++) begin
                        @(negedge clk_100mhz);
                    end
                    check_eq(led, want_led, "board count on led");
                    boards_checked++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_100mhz);
        $display("Timeout after %0d cycles, the DUT stopped sending tallies", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(80));
        rst_n = 1'b0;
        rx    = 1'b1;  // Idle line
        model = '0;
        repeat (10) @(posedge clk_100mhz);
        #1 rst_n = 1'b1;
        repeat (4 * CLKS_PER_BIT) @(posedge clk_100mhz);

        // Full 8x8 with random cells
        send_header(8, 8);
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) send_assign(r, c, 1'($urandom_range(1, 0)));
        end
        finish_board();

        // 3x5, columns 5 to 7 always set but masked
        send_header(3, 5);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 8; c++) begin
                send_assign(r, c, (c >= 5) ? 1'b1 : 1'($urandom_range(1, 0)));
            end
        end
        finish_board();

        // Fresh header after a busy board, only four cells set
        send_header(8, 8);
        send_assign(0, 0, 1'b1);
        send_assign(2, 7, 1'b1);
        send_assign(5, 3, 1'b1);
        send_assign(7, 7, 1'b1);
        finish_board();

        // Junk before the header and assignments after the end
        send_byte(8'h13);
        send_byte(8'h80);
        send_byte(8'h25);
        send_header(2, 8);
        send_assign(0, 1, 1'b1);
        send_assign(1, 2, 1'b1);
        send_assign(1, 6, 1'b1);
        send_assign(0, 7, 1'b0);
        finish_board();
        send_byte(8'h31);
        send_byte(8'h5F);

        // Framing error in LOAD, the row 3 col 7 write never lands
        send_header(4, 8);
        send_assign(0, 1, 1'b1);
        send_assign(1, 3, 1'b1);
        send_assign(2, 5, 1'b1);
        send_assign(3, 0, 1'b1);
        send_assign(3, 2, 1'b1);
        send_assign(0, 6, 1'b1);
        send_frame({1'b0, 3'd3, 3'd7, 1'b1}, 1'b0);
        finish_board();

        repeat (20 * CLKS_PER_BIT) @(posedge clk_100mhz);  // Quiet line, catch stray bytes
        $display("%0d errors over %0d boards", errors, boards_checked);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
